// File: rtl/red_pkg.sv
package red_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Element width in bits.
    localparam int SEW = 8;

    // Elements held by one vector register.
    localparam int ELEMS_PER_REG = 8;

    // Largest register group handled by one reduction.
    localparam int MAX_REGS = 8;

    // vl covers 0 to MAX_REGS * ELEMS_PER_REG elements.
    localparam int VL_W = 7;

    // Register index within the group.
    localparam int REG_IDX_W = 3;

    // ----------------------------------------
    // Data types
    // ----------------------------------------

    typedef logic [SEW-1:0] elem_t;

    // Lane 0 sits in the low byte.
    typedef logic [ELEMS_PER_REG-1:0][SEW-1:0] vreg_t;

    // One row of lane bits per register of the group.
    typedef logic [MAX_REGS-1:0][ELEMS_PER_REG-1:0] mask_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    typedef enum logic [2:0] {
        RED_SUM  = 3'd0,
        RED_MAX  = 3'd1,
        RED_MAXU = 3'd2,
        RED_MIN  = 3'd3,
        RED_MINU = 3'd4,
        RED_AND  = 3'd5,
        RED_OR   = 3'd6,
        RED_XOR  = 3'd7
    } red_op_e;

    // Control sequence of one reduction.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } red_state_e;

endpackage

// File: rtl/red_cycle_counter.sv
`timescale 1ns/100ps

module red_cycle_counter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clear,
    input  logic                          step,
    input  logic [3:0]                    num_regs,
    output logic [red_pkg::REG_IDX_W-1:0] reg_idx,
    output logic                          last
);

    // Index of the register being combined.
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_idx <= '0;
        end else if (clear) begin
            reg_idx <= '0;
        end else if (step) begin
            reg_idx <= reg_idx + 1'b1;
        end
    end

    // Final register of the group.
    assign last = ({1'b0, reg_idx} == (num_regs - 4'd1));

endmodule

// File: rtl/red_control_fsm.sv
`timescale 1ns/100ps

module red_control_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic busy,
    output logic done
);

    red_pkg::red_state_e state_q;
    red_pkg::red_state_e state_d;

    // ----------------------------------------
    // State register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= red_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            red_pkg::IDLE: begin
                if (start) begin
                    state_d = red_pkg::RUN;
                end
            end
            red_pkg::RUN: begin
                // One register per cycle until the last one.
                if (last) begin
                    state_d = red_pkg::DONE;
                end
            end
            red_pkg::DONE: begin
                state_d = red_pkg::IDLE;
            end
            default: begin
                state_d = red_pkg::IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // Start is only honoured while idle.
    assign load = (state_q == red_pkg::IDLE) && start;
    assign step = (state_q == red_pkg::RUN);
    assign busy = (state_q == red_pkg::RUN) || (state_q == red_pkg::DONE);
    assign done = (state_q == red_pkg::DONE);

endmodule

// File: rtl/red_lane_mask.sv
`timescale 1ns/100ps

module red_lane_mask (
    input  logic [red_pkg::VL_W-1:0]          vl,
    input  logic                              vm,
    input  red_pkg::mask_t                    mask,
    input  logic [red_pkg::REG_IDX_W-1:0]     reg_idx,
    output logic [red_pkg::ELEMS_PER_REG-1:0] active
);

    logic [red_pkg::ELEMS_PER_REG-1:0] row;
    logic [red_pkg::VL_W-1:0]          elem_idx;

    // Mask row of the current register.
    assign row = mask[reg_idx];

    always_comb begin
        // First element of this register in the group.
        elem_idx = {1'b0, reg_idx, 3'b000};
        for (int i = 0; i < red_pkg::ELEMS_PER_REG; i++) begin
            active[i] = (elem_idx < vl) && (vm || row[i]);
            elem_idx  = elem_idx + 1'b1;
        end
    end

endmodule

// File: rtl/red_tree_accum.sv
`timescale 1ns/100ps

module red_tree_accum (
    input  logic                              clk,
    input  logic                              reset,
    input  red_pkg::red_op_e                  op,
    input  red_pkg::vreg_t                    operand,
    input  logic [red_pkg::ELEMS_PER_REG-1:0] active,
    input  logic                              load,
    input  red_pkg::elem_t                    init,
    input  logic                              step,
    output red_pkg::elem_t                    acc
);

    red_pkg::elem_t fill [red_pkg::ELEMS_PER_REG];
    red_pkg::elem_t lvl1 [red_pkg::ELEMS_PER_REG/2];
    red_pkg::elem_t lvl2 [red_pkg::ELEMS_PER_REG/4];
    red_pkg::elem_t tree_out;

    // ----------------------------------------
    // Operators
    // ----------------------------------------

    function automatic red_pkg::elem_t combine(
        input red_pkg::red_op_e f,
        input red_pkg::elem_t   a,
        input red_pkg::elem_t   b
    );
        case (f)
            red_pkg::RED_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            red_pkg::RED_MAXU: return (a > b) ? a : b;
            red_pkg::RED_MIN:  return ($signed(a) > $signed(b)) ? b : a;
            red_pkg::RED_MINU: return (a > b) ? b : a;
            red_pkg::RED_AND:  return a & b;
            red_pkg::RED_OR:   return a | b;
            red_pkg::RED_XOR:  return a ^ b;
            default:           return a + b;
        endcase
    endfunction

    // Value that leaves the other operand unchanged.
    function automatic red_pkg::elem_t identity(input red_pkg::red_op_e f);
        case (f)
            red_pkg::RED_MIN:  return {1'b0, {(red_pkg::SEW-1){1'b1}}};
            red_pkg::RED_MAX:  return {1'b1, {(red_pkg::SEW-1){1'b0}}};
            red_pkg::RED_MINU: return '1;
            red_pkg::RED_AND:  return '1;
            default:           return '0;
        endcase
    endfunction

    // ----------------------------------------
    // Reduction tree
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < red_pkg::ELEMS_PER_REG; i++) begin
            fill[i] = active[i] ? operand[i] : identity(op);
        end
        for (int i = 0; i < red_pkg::ELEMS_PER_REG/2; i++) begin
            lvl1[i] = combine(op, fill[2*i], fill[2*i+1]);
        end
        for (int i = 0; i < red_pkg::ELEMS_PER_REG/4; i++) begin
            lvl2[i] = combine(op, lvl1[2*i], lvl1[2*i+1]);
        end
        tree_out = combine(op, lvl2[0], lvl2[1]);
    end

    // ----------------------------------------
    // Accumulator
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (load) begin
            // Scalar seed.
            acc <= init;
        end else if (step) begin
            acc <= combine(op, acc, tree_out);
        end
    end

endmodule

// File: rtl/vector_reduction_top.sv
`timescale 1ns/100ps

module vector_reduction_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  red_pkg::red_op_e              op,
    input  logic [red_pkg::VL_W-1:0]      vl,
    input  logic                          vm,
    input  red_pkg::mask_t                mask,
    input  logic [3:0]                    num_regs,
    input  red_pkg::elem_t                init,
    output logic [red_pkg::REG_IDX_W-1:0] vreg_rd_idx,
    input  red_pkg::vreg_t                vreg_rd_data,
    output logic                          busy,
    output logic                          done,
    output red_pkg::elem_t                result
);

    logic                              load;
    logic                              step;
    logic                              last;
    logic [red_pkg::ELEMS_PER_REG-1:0] active;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    red_control_fsm u_ctrl (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .last  (last),
        .load  (load),
        .step  (step),
        .busy  (busy),
        .done  (done)
    );

    // Register index doubles as the read address.
    red_cycle_counter u_count (
        .clk      (clk),
        .reset    (reset),
        .clear    (load),
        .step     (step),
        .num_regs (num_regs),
        .reg_idx  (vreg_rd_idx),
        .last     (last)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    red_lane_mask u_lanes (
        .vl      (vl),
        .vm      (vm),
        .mask    (mask),
        .reg_idx (vreg_rd_idx),
        .active  (active)
    );

    red_tree_accum u_tree (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .operand (vreg_rd_data),
        .active  (active),
        .load    (load),
        .init    (init),
        .step    (step),
        .acc     (result)
    );

endmodule

// File: tb/vred_tb.sv
`timescale 1ns/100ps

module vred_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 15;
    // Each row takes at most MAX_REGS + 6 cycles.
    localparam int WATCHDOG_NS  =
        (NUM_ROWS * (red_pkg::MAX_REGS + 6) + RESET_CYCLES + 4) * CLK_PERIOD;

    typedef struct packed {
        red_pkg::red_op_e         op;
        logic [red_pkg::VL_W-1:0] vl;
        logic                     vm;
        logic [3:0]               num_regs;
        red_pkg::elem_t           init;
        logic [1:0]               mask_sel;
        logic                     restart;
    } test_row_t;

    // Mask select 0 is all ones, 1 random, 2 alternating lanes.
    // Restart sends a second start pulse while busy.
    test_row_t rows [NUM_ROWS] = '{
        '{red_pkg::RED_SUM,  7'd8,  1'b1, 4'd1, 8'hF0, 2'd0, 1'b0},
        '{red_pkg::RED_SUM,  7'd64, 1'b1, 4'd8, 8'h7F, 2'd0, 1'b0},
        '{red_pkg::RED_MAX,  7'd16, 1'b1, 4'd2, 8'h80, 2'd0, 1'b0},
        '{red_pkg::RED_MAXU, 7'd16, 1'b1, 4'd2, 8'h00, 2'd0, 1'b0},
        '{red_pkg::RED_MIN,  7'd64, 1'b1, 4'd8, 8'h7F, 2'd0, 1'b0},
        '{red_pkg::RED_MINU, 7'd8,  1'b1, 4'd1, 8'hFF, 2'd0, 1'b0},
        '{red_pkg::RED_AND,  7'd16, 1'b1, 4'd2, 8'hFF, 2'd0, 1'b0},
        '{red_pkg::RED_OR,   7'd8,  1'b1, 4'd1, 8'h00, 2'd0, 1'b0},
        '{red_pkg::RED_XOR,  7'd64, 1'b1, 4'd8, 8'h5A, 2'd0, 1'b0},
        '{red_pkg::RED_MIN,  7'd32, 1'b0, 4'd4, 8'h7F, 2'd1, 1'b0},
        '{red_pkg::RED_MAX,  7'd24, 1'b0, 4'd3, 8'h80, 2'd2, 1'b0},
        '{red_pkg::RED_AND,  7'd4,  1'b0, 4'd1, 8'hFF, 2'd2, 1'b0},
        '{red_pkg::RED_SUM,  7'd37, 1'b0, 4'd8, 8'h11, 2'd2, 1'b1},
        '{red_pkg::RED_XOR,  7'd0,  1'b1, 4'd4, 8'hA5, 2'd0, 1'b0},
        '{red_pkg::RED_MINU, 7'd13, 1'b0, 4'd2, 8'hFF, 2'd1, 1'b1}
    };

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          start;
    red_pkg::red_op_e              op;
    logic [red_pkg::VL_W-1:0]      vl;
    logic                          vm;
    red_pkg::mask_t                mask;
    logic [3:0]                    num_regs;
    red_pkg::elem_t                init;
    logic [red_pkg::REG_IDX_W-1:0] vreg_rd_idx;
    red_pkg::vreg_t                vreg_rd_data;
    logic                          busy;
    logic                          done;
    red_pkg::elem_t                result;

    red_pkg::vreg_t regfile [red_pkg::MAX_REGS];
    integer         seed;
    int             error_count;
    int             pass_count;
    int             fail_count;

    vector_reduction_top uut (.*);

    // Register file answers in the same cycle.
    assign vreg_rd_data = regfile[vreg_rd_idx];

    always #(CLK_PERIOD/2) clk = ~clk;

    // Folds init and every lane of the group in order.
    function automatic red_pkg::elem_t model_reduce(input test_row_t t, input red_pkg::mask_t m);
        red_pkg::elem_t a;
        red_pkg::elem_t e;
        red_pkg::elem_t fill;
        case (t.op)
            red_pkg::RED_MIN:                    fill = 8'h7F;
            red_pkg::RED_MAX:                    fill = 8'h80;
            red_pkg::RED_MINU, red_pkg::RED_AND: fill = 8'hFF;
            default:                             fill = 8'h00;
        endcase
        a = t.init;
        for (int k = 0; k < int'(t.num_regs); k++) begin
            for (int i = 0; i < red_pkg::ELEMS_PER_REG; i++) begin
                e = fill;
                if ((k * red_pkg::ELEMS_PER_REG + i < int'(t.vl)) &&
                    (t.vm || m[k][i])) begin
                    e = regfile[k][i];
                end
                case (t.op)
                    red_pkg::RED_SUM:  a = 8'((int'(a) + int'(e)) % 256);
                    red_pkg::RED_MAX:  a = ($signed(e) > $signed(a)) ? e : a;
                    red_pkg::RED_MAXU: a = (e > a) ? e : a;
                    red_pkg::RED_MIN:  a = ($signed(e) < $signed(a)) ? e : a;
                    red_pkg::RED_MINU: a = (e < a) ? e : a;
                    red_pkg::RED_AND:  a = a & e;
                    red_pkg::RED_OR:   a = a | e;
                    default:           a = a ^ e;
                endcase
            end
        end
        return a;
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic check_elem(input string name, input red_pkg::elem_t expected,
                              input red_pkg::elem_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %02h actual %02h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %0b actual %0b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_latency(input int expected, input int actual, input logic seen);
        if (!seen) begin
            $display("Error at %0t: done did not arrive within %0d cycles", $time, actual);
            error_count++;
        end else if (actual != expected) begin
            $display("Error at %0t: done arrived %0d cycles after start, expected %0d",
                     $time, actual, expected);
            error_count++;
        end
    endtask

    // ----------------------------------------
    // One table row
    // ----------------------------------------

    task automatic run_row(input int r);
        red_pkg::mask_t m;
        red_pkg::elem_t expected;
        int             cycles;
        int             errors_before;
        logic           seen;
        errors_before = error_count;
        for (int k = 0; k < red_pkg::MAX_REGS; k++) begin
            regfile[k] = {$random(seed), $random(seed)};
        end
        case (rows[r].mask_sel)
            2'd1:    m = {$random(seed), $random(seed)};
            2'd2:    m = 64'h5555_5555_5555_5555;
            default: m = '1;
        endcase
        expected = model_reduce(rows[r], m);
        @(posedge clk);
        op       <= rows[r].op;
        vl       <= rows[r].vl;
        vm       <= rows[r].vm;
        mask     <= m;
        num_regs <= rows[r].num_regs;
        init     <= rows[r].init;
        start    <= 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < red_pkg::MAX_REGS + 4) begin
            @(posedge clk);
            // Second pulse lands while the unit is busy.
            start <= rows[r].restart && (cycles == 1);
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                check_bit("busy", 1'b1, busy);
            end
        end
        check_latency(int'(rows[r].num_regs) + 1, cycles, seen);
        check_bit("busy", 1'b1, busy);
        check_elem("result", expected, result);
        if (rows[r].vl == '0) begin
            check_elem("result", rows[r].init, result);
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        // No second done once back in idle.
        repeat (3) begin
            check_bit("done", 1'b0, done);
            @(negedge clk);
        end
        check_elem("result", expected, result);
        $display("Test %0d %s vl %0d regs %0d: expected %02h, got %02h, %s", r, op.name(),
                 vl, num_regs, expected, result,
                 (error_count == errors_before) ? "ok" : "failed");
        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        seed        = 70;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int k = 0; k < red_pkg::MAX_REGS; k++) begin
            regfile[k] = '0;
        end
        reset    <= 1'b1;
        start    <= 1'b0;
        op       <= red_pkg::RED_SUM;
        vl       <= '0;
        vm       <= 1'b0;
        mask     <= '0;
        num_regs <= 4'd1;
        init     <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t: the tests did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: list.f
rtl/red_pkg.sv
rtl/red_cycle_counter.sv
rtl/red_control_fsm.sv
rtl/red_lane_mask.sv
rtl/red_tree_accum.sv
rtl/vector_reduction_top.sv
tb/vred_tb.sv

// File: Makefile
TOP = vred_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Finished with errors" sim.log

obj_dir/V$(TOP): list.f rtl/*.sv tb/*.sv
	verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
